// ==== source/HazardPkg.sv ====
`default_nettype none

package HazardPkg;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpJ     = 6'h02,
        OpJal   = 6'h03,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddi  = 6'h08,
        OpAndi  = 6'h0c,
        OpOri   = 6'h0d,
        OpLui   = 6'h0f,
        OpLb    = 6'h20,
        OpLh    = 6'h21,
        OpLw    = 6'h23,
        OpSb    = 6'h28,
        OpSh    = 6'h29,
        OpSw    = 6'h2b
    } Opcode;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FnJr    = 6'h08,
        FnMfhi  = 6'h10,
        FnMthi  = 6'h11,
        FnMflo  = 6'h12,
        FnMtlo  = 6'h13,
        FnMult  = 6'h18,
        FnMultu = 6'h19,
        FnDiv   = 6'h1a,
        FnDivu  = 6'h1b,
        FnAdd   = 6'h20,
        FnSub   = 6'h22,
        FnAnd   = 6'h24,
        FnOr    = 6'h25,
        FnSlt   = 6'h2a,
        FnSltu  = 6'h2b
    } Funct;

    ////////////////////////////////////////////////////////////
    // Timing and operand types
    ////////////////////////////////////////////////////////////

    // Cycles until use (Tuse) or until result is ready (Tnew)
    typedef logic [1:0] StageTime;

    // Zero stands for no register
    typedef logic [4:0] RegNum;

    typedef enum logic [1:0] {
        MduNone,
        MduOperate,
        MduHiLo
    } MduClass;

endpackage

`default_nettype wire

// ==== source/HazardIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// Results in flight in E and M
interface ProducerIf import HazardPkg::*; ();
    RegNum    destE;
    StageTime tnewE;
    RegNum    destM;
    StageTime tnewM;

    modport tracker (output destE, tnewE, destM, tnewM);
    modport check (input destE, tnewE, destM, tnewM);
endinterface

// Operands needed by D, plus the multiply/divide class of D and E
interface ConsumerIf import HazardPkg::*; ();
    RegNum    rsUse;
    RegNum    rtUse;
    StageTime tuseRs;
    StageTime tuseRt;
    MduClass  mduClassD;
    MduClass  mduClassE;

    modport decoder (output rsUse, rtUse, tuseRs, tuseRt, mduClassD, mduClassE);
    modport check (input rsUse, rtUse, tuseRs, tuseRt, mduClassD, mduClassE);
endinterface

`default_nettype wire

// ==== source/OperandUseDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module OperandUseDecoder import HazardPkg::*; (
    input  logic [31:0] instrD,
    input  logic [31:0] instrE,
    ConsumerIf.decoder  uses
);

    Opcode opD;
    Funct  fnD;
    RegNum rs;
    RegNum rt;

    function automatic MduClass mduKind(input logic [31:0] instr);
        MduClass kind;
        kind = MduNone;
        if (Opcode'(instr[31:26]) == OpRType) begin
            case (Funct'(instr[5:0]))
                FnMult, FnMultu, FnDiv, FnDivu: kind = MduOperate;
                FnMfhi, FnMflo, FnMthi, FnMtlo: kind = MduHiLo;
                default: kind = MduNone;
            endcase
        end
        return kind;
    endfunction

    assign opD = Opcode'(instrD[31:26]);
    assign fnD = Funct'(instrD[5:0]);
    assign rs  = instrD[25:21];
    assign rt  = instrD[20:16];

    // Source registers and how many cycles until each is needed
    always_comb begin
        uses.rsUse  = '0;
        uses.rtUse  = '0;
        uses.tuseRs = 2'd0;
        uses.tuseRt = 2'd0;
        case (opD)
            OpRType: begin
                case (fnD)
                    FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu,
                    FnMult, FnMultu, FnDiv, FnDivu: begin
                        uses.rsUse  = rs;
                        uses.rtUse  = rt;
                        uses.tuseRs = 2'd1;
                        uses.tuseRt = 2'd1;
                    end
                    FnMthi, FnMtlo: begin
                        uses.rsUse  = rs;
                        uses.tuseRs = 2'd1;
                    end
                    // Jump target is needed in D
                    FnJr: uses.rsUse = rs;
                    default: ;
                endcase
            end
            OpAddi, OpAndi, OpOri, OpLw, OpLb, OpLh: begin
                uses.rsUse  = rs;
                uses.tuseRs = 2'd1;
            end
            OpSw, OpSb, OpSh: begin
                uses.rsUse  = rs;
                uses.rtUse  = rt;
                uses.tuseRs = 2'd1;
                uses.tuseRt = 2'd2;
            end
            // Compared in D
            OpBeq, OpBne: begin
                uses.rsUse = rs;
                uses.rtUse = rt;
            end
            default: ;
        endcase
    end

    assign uses.mduClassD = mduKind(instrD);
    assign uses.mduClassE = mduKind(instrE);

endmodule

`default_nettype wire

// ==== source/ProducerTracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ProducerTracker import HazardPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrE,
    input  logic        regWriteE,
    ProducerIf.tracker  prod
);

    localparam RegNum LinkReg = 5'd31;

    Opcode    opE;
    Funct     fnE;
    RegNum    rtE;
    RegNum    rdE;
    RegNum    destRaw;
    StageTime tnewRaw;

    assign opE = Opcode'(instrE[31:26]);
    assign fnE = Funct'(instrE[5:0]);
    assign rtE = instrE[20:16];
    assign rdE = instrE[15:11];

    ////////////////////////////////////////////////////////////
    // E stage destination and Tnew
    ////////////////////////////////////////////////////////////
    always_comb begin
        destRaw = '0;
        tnewRaw = 2'd0;
        case (opE)
            OpRType: begin
                case (fnE)
                    FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu,
                    FnMfhi, FnMflo: begin
                        destRaw = rdE;
                        tnewRaw = 2'd1;
                    end
                    default: ;
                endcase
            end
            OpAddi, OpAndi, OpOri, OpLui: begin
                destRaw = rtE;
                tnewRaw = 2'd1;
            end
            // Data arrives from memory one stage later
            OpLw, OpLb, OpLh: begin
                destRaw = rtE;
                tnewRaw = 2'd2;
            end
            // Return address is known already in E
            OpJal: destRaw = LinkReg;
            default: ;
        endcase
    end

    assign prod.destE = regWriteE ? destRaw : '0;
    assign prod.tnewE = tnewRaw;

    ////////////////////////////////////////////////////////////
    // Aged copy for M
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            prod.destM <= '0;
            prod.tnewM <= 2'd0;
        end else begin
            prod.destM <= prod.destE;
            prod.tnewM <= (prod.tnewE == 2'd0) ? 2'd0 : prod.tnewE - 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/MduSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module MduSequencer import HazardPkg::*; #(
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrE,
    ConsumerIf.check    uses,
    output logic        busy,
    output logic        starting
);

    localparam int MaxCycles  = (MultCycles > DivCycles) ? MultCycles : DivCycles;
    localparam int CountWidth = $clog2(MaxCycles + 1);

    logic [CountWidth-1:0] count;
    Funct                  fnE;
    logic                  isDiv;

    assign fnE      = Funct'(instrE[5:0]);
    assign isDiv    = (fnE == FnDiv) || (fnE == FnDivu);
    assign starting = (uses.mduClassE == MduOperate);

    // Load in the start cycle, then count down one per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (starting) begin
            count <= isDiv ? CountWidth'(DivCycles) : CountWidth'(MultCycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

endmodule

`default_nettype wire

// ==== source/StallController.sv ====
`timescale 1ns/1ns
`default_nettype none

module StallController import HazardPkg::*; (
    ProducerIf.check prod,
    ConsumerIf.check uses,
    input  logic     busy,
    input  logic     starting,
    output logic     pcWrite,
    output logic     ifIdEnable,
    output logic     idExClear,
    output logic     mduClear
);

    logic rsHitE;
    logic rsHitM;
    logic rtHitE;
    logic rtHitM;
    logic mduActive;
    logic stall;

    // Value would arrive after the consumer needs it
    function automatic logic lateResult(
        input RegNum    src,
        input StageTime tuse,
        input RegNum    dest,
        input StageTime tnew
    );
        return (src != '0) && (src == dest) && (tuse < tnew);
    endfunction

    assign rsHitE = lateResult(uses.rsUse, uses.tuseRs, prod.destE, prod.tnewE);
    assign rsHitM = lateResult(uses.rsUse, uses.tuseRs, prod.destM, prod.tnewM);
    assign rtHitE = lateResult(uses.rtUse, uses.tuseRt, prod.destE, prod.tnewE);
    assign rtHitM = lateResult(uses.rtUse, uses.tuseRt, prod.destM, prod.tnewM);

    assign mduActive = busy || starting;

    ////////////////////////////////////////////////////////////
    // Pipeline controls
    ////////////////////////////////////////////////////////////
    assign stall = rsHitE || rsHitM || rtHitE || rtHitM
                || (mduActive && (uses.mduClassD == MduHiLo));

    assign pcWrite    = ~stall;
    assign ifIdEnable = ~stall;
    assign idExClear  = stall;

    // New multiply/divide in D while the unit is still working
    assign mduClear = mduActive && (uses.mduClassD == MduOperate);

endmodule

`default_nettype wire

// ==== source/HazardUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module HazardUnit #(
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrD,
    input  logic [31:0] instrE,
    input  logic        regWriteE,
    output logic        pcWrite,
    output logic        ifIdEnable,
    output logic        idExClear,
    output logic        mduClear,
    output logic        mduBusy
);

    ProducerIf prodIf ();
    ConsumerIf useIf ();

    logic busy;
    logic starting;

    OperandUseDecoder decoder (
        .instrD (instrD),
        .instrE (instrE),
        .uses   (useIf)
    );

    ProducerTracker tracker (
        .clk       (clk),
        .reset     (reset),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .prod      (prodIf)
    );

    MduSequencer #(
        .MultCycles (MultCycles),
        .DivCycles  (DivCycles)
    ) sequencer (
        .clk      (clk),
        .reset    (reset),
        .instrE   (instrE),
        .uses     (useIf),
        .busy     (busy),
        .starting (starting)
    );

    StallController controller (
        .prod       (prodIf),
        .uses       (useIf),
        .busy       (busy),
        .starting   (starting),
        .pcWrite    (pcWrite),
        .ifIdEnable (ifIdEnable),
        .idExClear  (idExClear),
        .mduClear   (mduClear)
    );

    assign mduBusy = busy;

endmodule

`default_nettype wire

// ==== sim/HazardUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module HazardUnitTb import HazardPkg::*; ();

    localparam int MultCycles = 5;
    localparam int DivCycles  = 10;
    localparam int WaitLimit  = 40;

    localparam Funct RFns [15] = '{
        FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu, FnJr, FnMult,
        FnMultu, FnDiv, FnDivu, FnMfhi, FnMflo, FnMthi, FnMtlo
    };
    localparam Opcode IOps [12] = '{
        OpAddi, OpAndi, OpOri, OpLui, OpLw, OpLb, OpLh, OpSw, OpSb, OpSh, OpBeq, OpBne
    };

    typedef struct packed {
        logic pcWrite;
        logic ifIdEnable;
        logic idExClear;
        logic mduClear;
        logic mduBusy;
    } Controls;

    // Register read by D and cycles until needed
    typedef struct packed {
        RegNum    num;
        StageTime tuse;
    } Need;

    // Register written and cycles until ready
    typedef struct packed {
        RegNum    dest;
        StageTime tnew;
    } Result;

    logic        clk;
    logic        reset;
    logic [31:0] instrD;
    logic [31:0] instrE;
    logic        regWriteE;
    logic        pcWrite;
    logic        ifIdEnable;
    logic        idExClear;
    logic        mduClear;
    logic        mduBusy;

    RegNum    modelDestM;
    StageTime modelTnewM;
    int       modelCount;
    int       seed;

    HazardUnit UUT (
        .clk        (clk),
        .reset      (reset),
        .instrD     (instrD),
        .instrE     (instrE),
        .regWriteE  (regWriteE),
        .pcWrite    (pcWrite),
        .ifIdEnable (ifIdEnable),
        .idExClear  (idExClear),
        .mduClear   (mduClear),
        .mduBusy    (mduBusy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] rType(input Funct fn, input RegNum rs,
                                          input RegNum rt, input RegNum rd);
        return {OpRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input Opcode op, input RegNum rs,
                                          input RegNum rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input Opcode op);
        return {op, 26'd0};
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model of the Tuse/Tnew rules
    ////////////////////////////////////////////////////////////
    function automatic logic isR(input logic [31:0] instr, input Funct fn);
        return (instr[31:26] == OpRType) && (instr[5:0] == fn);
    endfunction

    function automatic logic isRAlu(input logic [31:0] instr);
        return (instr[31:26] == OpRType)
            && (instr[5:0] inside {FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu});
    endfunction

    function automatic MduClass mduKind(input logic [31:0] instr);
        if (isR(instr, FnMult) || isR(instr, FnMultu) || isR(instr, FnDiv)
                || isR(instr, FnDivu))
            return MduOperate;
        if (isR(instr, FnMfhi) || isR(instr, FnMflo) || isR(instr, FnMthi)
                || isR(instr, FnMtlo))
            return MduHiLo;
        return MduNone;
    endfunction

    function automatic Need rsNeed(input logic [31:0] instr);
        Need n;
        n.num  = instr[25:21];
        n.tuse = 2'd1;
        if (instr[31:26] inside {OpBeq, OpBne} || isR(instr, FnJr)) begin
            n.tuse = 2'd0;
        end else if (!(isRAlu(instr) || mduKind(instr) == MduOperate
                || isR(instr, FnMthi) || isR(instr, FnMtlo)
                || instr[31:26] inside {OpAddi, OpAndi, OpOri, OpLw, OpLb, OpLh,
                                        OpSw, OpSb, OpSh})) begin
            n.num = 5'd0;
        end
        return n;
    endfunction

    function automatic Need rtNeed(input logic [31:0] instr);
        Need n;
        n.num  = instr[20:16];
        n.tuse = 2'd0;
        if (isRAlu(instr) || mduKind(instr) == MduOperate)
            n.tuse = 2'd1;
        else if (instr[31:26] inside {OpSw, OpSb, OpSh})
            n.tuse = 2'd2;
        else if (!(instr[31:26] inside {OpBeq, OpBne}))
            n.num = 5'd0;
        return n;
    endfunction

    function automatic Result producer(input logic [31:0] instr, input logic we);
        Result r;
        r.dest = 5'd0;
        r.tnew = 2'd0;
        if (instr[31:26] inside {OpLw, OpLb, OpLh}) begin
            r.dest = instr[20:16];
            r.tnew = 2'd2;
        end else if (instr[31:26] inside {OpAddi, OpAndi, OpOri, OpLui}) begin
            r.dest = instr[20:16];
            r.tnew = 2'd1;
        end else if (isRAlu(instr) || isR(instr, FnMfhi) || isR(instr, FnMflo)) begin
            r.dest = instr[15:11];
            r.tnew = 2'd1;
        end else if (instr[31:26] == OpJal) begin
            r.dest = 5'd31;
        end
        if (!we)
            r.dest = 5'd0;
        return r;
    endfunction

    function automatic logic late(input Need n, input RegNum dest, input StageTime tnew);
        return (n.num != 5'd0) && (n.num == dest) && (n.tuse < tnew);
    endfunction

    // Called at each rising edge, before new inputs are driven
    task automatic advanceModel();
        Result r;
        r = producer(instrE, regWriteE);
        if (reset) begin
            modelDestM = 5'd0;
            modelTnewM = 2'd0;
            modelCount = 0;
        end else begin
            modelDestM = r.dest;
            modelTnewM = (r.tnew == 2'd0) ? 2'd0 : r.tnew - 2'd1;
            if (mduKind(instrE) == MduOperate)
                modelCount = (isR(instrE, FnDiv) || isR(instrE, FnDivu)) ? DivCycles : MultCycles;
            else if (modelCount > 0)
                modelCount = modelCount - 1;
        end
    endtask

    task automatic referenceModel(output Controls exp);
        Need   useRs;
        Need   useRt;
        Result resE;
        logic  active;
        logic  stall;
        useRs  = rsNeed(instrD);
        useRt  = rtNeed(instrD);
        resE   = producer(instrE, regWriteE);
        active = (modelCount != 0) || (mduKind(instrE) == MduOperate);
        stall  = late(useRs, resE.dest, resE.tnew) || late(useRs, modelDestM, modelTnewM)
              || late(useRt, resE.dest, resE.tnew) || late(useRt, modelDestM, modelTnewM)
              || (active && mduKind(instrD) == MduHiLo);
        exp.pcWrite    = !stall;
        exp.ifIdEnable = !stall;
        exp.idExClear  = stall;
        exp.mduClear   = active && (mduKind(instrD) == MduOperate);
        exp.mduBusy    = (modelCount != 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %b, expected %b", $time, what, actual,
                     expected);
            $display("*** FAILED ***");
            $fatal(1, "single-bit control wrong");
        end
    endtask

    task automatic checkControls(input Controls actual, input Controls expected,
                                 input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %b, expected %b (D %h, E %h)", $time,
                     what, actual, expected, instrD, instrE);
            $display("*** FAILED ***");
            $fatal(1, "control group wrong");
        end
    endtask

    task automatic checkCount(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
            $display("*** FAILED ***");
            $fatal(1, "cycle count wrong");
        end
    endtask

    function automatic Controls current();
        return {pcWrite, ifIdEnable, idExClear, mduClear, mduBusy};
    endfunction

    // One clock of model update, drive and compare
    task automatic step(input logic [31:0] d, input logic [31:0] e, input logic we,
                        input string what);
        Controls exp;
        @(posedge clk);
        advanceModel();
        #1;
        instrD    = d;
        instrE    = e;
        regWriteE = we;
        #1;
        referenceModel(exp);
        checkControls(current(), exp, what);
    endtask

    task automatic flush();
        step(32'h0, 32'h0, 1'b0, "flush");
        step(32'h0, 32'h0, 1'b0, "flush");
    endtask

    task automatic waitIdle();
        int waits;
        waits = 0;
        while (mduBusy) begin
            if (waits == WaitLimit) begin
                $display("Timeout: multiply/divide unit stayed busy");
                $display("*** FAILED ***");
                $fatal(1, "timeout");
            end
            waits++;
            step(32'h0, 32'h0, 1'b0, "drain busy");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic loadUse();
        step(rType(FnAdd, 5'd5, 5'd6, 5'd7), iType(OpLw, 5'd1, 5'd5, 16'h0), 1'b1, "lw E");
        checkBit(idExClear, 1'b1, "add after lw stalls");
        step(rType(FnAdd, 5'd5, 5'd6, 5'd7), 32'h0, 1'b0, "lw M");
        checkBit(idExClear, 1'b0, "add with lw in M");
        step(iType(OpSw, 5'd2, 5'd5, 16'h4), iType(OpLw, 5'd1, 5'd5, 16'h0), 1'b1, "sw rt");
        checkBit(idExClear, 1'b0, "store data after lw");
        flush();
    endtask

    task automatic branchHazard();
        logic [31:0] beq;
        beq = iType(OpBeq, 5'd8, 5'd9, 16'h2);
        step(beq, rType(FnAdd, 5'd1, 5'd2, 5'd8), 1'b1, "beq vs add E");
        checkBit(idExClear, 1'b1, "beq after add stalls");
        step(beq, 32'h0, 1'b0, "beq vs add M");
        checkBit(idExClear, 1'b0, "beq with add in M");
        step(iType(OpBeq, 5'd31, 5'd0, 16'h0), jType(OpJal), 1'b1, "beq vs jal");
        checkBit(idExClear, 1'b0, "reader of r31 after jal");
        flush();
    endtask

    task automatic nonWriters();
        step(iType(OpBeq, 5'd0, 5'd0, 16'h0), iType(OpLw, 5'd1, 5'd0, 16'h0), 1'b1, "r0");
        checkBit(idExClear, 1'b0, "write to r0");
        step(rType(FnAdd, 5'd5, 5'd5, 5'd1), iType(OpLw, 5'd1, 5'd5, 16'h0), 1'b0, "we low");
        checkBit(idExClear, 1'b0, "regWriteE low");
        step(rType(FnAdd, 5'd5, 5'd5, 5'd1), iType(OpSw, 5'd1, 5'd5, 16'h0), 1'b1, "sw E");
        checkBit(idExClear, 1'b0, "store in E");
        step(rType(FnAdd, 5'd5, 5'd5, 5'd1), 32'h0, 1'b0, "sw M");
        checkBit(idExClear, 1'b0, "store in M");
        flush();
    endtask

    task automatic busyLength(input Funct fn, input int expected, input string what);
        logic [31:0] mfhi;
        int          busyCycles;
        mfhi       = rType(FnMfhi, 5'd0, 5'd0, 5'd10);
        busyCycles = 0;
        step(mfhi, rType(fn, 5'd1, 5'd2, 5'd0), 1'b0, what);
        checkBit(idExClear, 1'b1, "mfhi in start cycle");
        step(mfhi, 32'h0, 1'b0, what);
        while (mduBusy) begin
            checkBit(idExClear, 1'b1, "mfhi while busy");
            busyCycles++;
            if (busyCycles > WaitLimit) begin
                $display("Timeout: mduBusy did not fall after %s", what);
                $display("*** FAILED ***");
                $fatal(1, "timeout");
            end
            step(mfhi, 32'h0, 1'b0, what);
        end
        checkBit(idExClear, 1'b0, "mfhi released");
        checkCount(busyCycles, expected, what);
    endtask

    task automatic mduClearing();
        logic [31:0] div;
        div = rType(FnDiv, 5'd1, 5'd2, 5'd0);
        step(div, rType(FnMult, 5'd3, 5'd4, 5'd0), 1'b1, "div vs starting mult");
        checkBit(mduClear, 1'b1, "clear while starting");
        checkBit(idExClear, 1'b0, "no stall while starting");
        step(div, 32'h0, 1'b0, "div vs busy mult");
        checkBit(mduClear, 1'b1, "clear while busy");
        checkBit(idExClear, 1'b0, "no stall while busy");
        waitIdle();
        step(div, 32'h0, 1'b0, "div idle");
        checkBit(mduClear, 1'b0, "clear low when idle");
    endtask

    task automatic randomInstr(output logic [31:0] instr);
        logic [31:0] bits;
        int          pick;
        RegNum       rs;
        RegNum       rt;
        RegNum       rd;
        bits = $random(seed);
        pick = int'(bits[15:0]) % 29;
        // Registers 0 to 3 only to force matches
        rs   = {3'b000, bits[17:16]};
        rt   = {3'b000, bits[19:18]};
        rd   = {3'b000, bits[21:20]};
        if (pick < 15)
            instr = rType(RFns[pick[3:0]], rs, rt, rd);
        else if (pick < 27)
            instr = iType(IOps[4'(pick - 15)], rs, rt, bits[31:16]);
        else if (pick == 27)
            instr = jType(OpJ);
        else
            instr = jType(OpJal);
    endtask

    task automatic randomStream();
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] bits;
        for (int i = 0; i < 300; i++) begin
            randomInstr(d);
            randomInstr(e);
            bits = $random(seed);
            step(d, e, bits[0], "random stream");
        end
    endtask

    initial begin
        seed       = 32'h5667;
        reset      = 1'b1;
        instrD     = 32'h0;
        instrE     = 32'h0;
        regWriteE  = 1'b0;
        modelDestM = 5'd0;
        modelTnewM = 2'd0;
        modelCount = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        step(32'h0, 32'h0, 1'b0, "idle after reset");
        checkControls(current(), 5'b11000, "idle after reset");
        loadUse();
        branchHazard();
        nonWriters();
        busyLength(FnMult, MultCycles, "mult busy");
        busyLength(FnDiv, DivCycles, "div busy");
        mduClearing();
        randomStream();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/HazardPkg.sv
source/HazardIf.sv
source/OperandUseDecoder.sv
source/ProducerTracker.sv
source/MduSequencer.sv
source/StallController.sv
source/HazardUnit.sv
sim/HazardUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f verilog.f \
    --top-module HazardUnitTb \
    -Mdir obj_dir

./obj_dir/VHazardUnitTb
